/* Makefile */
# Verilator flow for the MiST board base

TOP := tb_mist_base

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f vlog.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^SIMULATION PASSED$$"

clean:
	rm -rf obj_dir

/* logic/base_config.svh */
// ------------------------------------------------
// Board base configuration
// Fixed widths, I/O controller command codes and
// synchronizer depth for the SPI receivers
// ------------------------------------------------
`ifndef BASE_CONFIG_SVH
`define BASE_CONFIG_SVH

// ROM download address width
`define BASE_ADDR_W       22

// Commands sent on CONF_DATA0
`define BASE_CMD_JOY0     8'h01
`define BASE_CMD_JOY1     8'h02
`define BASE_CMD_VMODE    8'h03
`define BASE_CMD_STATUS   8'h1E

`define BASE_SYNC_STAGES  2   // Flops per SPI input

`endif

/* logic/base_pkg.sv */
// ------------------------------------------------
// Board base types
// Vector types for bytes, words, addresses and
// colours, plus the configuration decoder states
// ------------------------------------------------
`include "base_config.svh"

package base_pkg;

    typedef logic [7:0]  byte_t;     // SPI byte
    typedef logic [31:0] word32_t;   // Joystick or status word

    typedef logic [`BASE_ADDR_W-1:0] ioctl_addr_t;

    // Colour components
    typedef logic [3:0] color4_t;    // Game side
    typedef logic [5:0] color6_t;    // VGA side

    // Configuration command decoder
    typedef enum logic [1:0] {
        CFG_CMD,    // Waiting for command byte
        CFG_DATA,   // Collecting payload
        CFG_SKIP    // Ignore rest of select
    } cfg_state_t;

endpackage

/* logic/mist_base.sv */
// ------------------------------------------------
// MiST board base
// Connects the ROM download and configuration SPI
// receivers and the video output stage
// ------------------------------------------------
`timescale 1ns/1ps

module mist_base
    import base_pkg::*;
(
    input  logic        clk_sys_i,
    input  logic        rst_n_i,
    // SPI from I/O controller
    input  logic        SPI_SCK_i,
    input  logic        SPI_DI_i,
    input  logic        SPI_SS2_i,
    input  logic        CONF_DATA0_i,
    // Game and scan-doubled video
    input  color4_t     game_r_i,
    input  color4_t     game_g_i,
    input  color4_t     game_b_i,
    input  color6_t     board_r_i,
    input  color6_t     board_g_i,
    input  color6_t     board_b_i,
    input  logic        hs_i,
    input  logic        vs_i,
    input  logic        board_hsync_i,
    input  logic        board_vsync_i,
    // ROM download
    output ioctl_addr_t ioctl_addr_o,
    output byte_t       ioctl_data_o,
    output logic        ioctl_wr_o,
    output logic        downloading_o,
    // Control words
    output word32_t     joystick1_o,
    output word32_t     joystick2_o,
    output word32_t     status_o,
    // VGA connector
    output color6_t     VGA_R_o,
    output color6_t     VGA_G_o,
    output color6_t     VGA_B_o,
    output logic        VGA_HS_o,
    output logic        VGA_VS_o
);

    logic  dl_valid, dl_first, dl_active;
    byte_t dl_data;
    logic  cfg_valid, cfg_first, cfg_active;
    byte_t cfg_data;
    logic  ypbpr, scandoubler_disable;

    spi_byte_rx u_spi_dl (
        .clk_sys_i    ( clk_sys_i ), .rst_n_i      ( rst_n_i   ),
        .sck_i        ( SPI_SCK_i ), .ss_n_i       ( SPI_SS2_i ),
        .sdi_i        ( SPI_DI_i  ), .byte_valid_o ( dl_valid  ),
        .first_byte_o ( dl_first  ), .ss_active_o  ( dl_active ),
        .byte_data_o  ( dl_data   )
    );

    spi_byte_rx u_spi_cfg (
        .clk_sys_i    ( clk_sys_i  ), .rst_n_i      ( rst_n_i      ),
        .sck_i        ( SPI_SCK_i  ), .ss_n_i       ( CONF_DATA0_i ),
        .sdi_i        ( SPI_DI_i   ), .byte_valid_o ( cfg_valid    ),
        .first_byte_o ( cfg_first  ), .ss_active_o  ( cfg_active   ),
        .byte_data_o  ( cfg_data   )
    );

    rom_download u_rom_download (
        .clk_sys_i     ( clk_sys_i     ), .rst_n_i      ( rst_n_i      ),
        .byte_valid_i  ( dl_valid      ), .first_byte_i ( dl_first     ),
        .ss_active_i   ( dl_active     ), .byte_data_i  ( dl_data      ),
        .ioctl_addr_o  ( ioctl_addr_o  ), .ioctl_data_o ( ioctl_data_o ),
        .ioctl_wr_o    ( ioctl_wr_o    ), .downloading_o( downloading_o )
    );

    user_cfg u_user_cfg (
        .clk_sys_i    ( clk_sys_i   ), .rst_n_i      ( rst_n_i     ),
        .byte_valid_i ( cfg_valid   ), .first_byte_i ( cfg_first   ),
        .ss_active_i  ( cfg_active  ), .byte_data_i  ( cfg_data    ),
        .joystick1_o  ( joystick1_o ), .joystick2_o  ( joystick2_o ),
        .status_o     ( status_o    ), .ypbpr_o      ( ypbpr       ),
        .scandoubler_disable_o ( scandoubler_disable )
    );

    video_out u_video_out (
        .clk_sys_i     ( clk_sys_i     ), .rst_n_i       ( rst_n_i       ),
        .game_r_i      ( game_r_i      ), .game_g_i      ( game_g_i      ),
        .game_b_i      ( game_b_i      ), .board_r_i     ( board_r_i     ),
        .board_g_i     ( board_g_i     ), .board_b_i     ( board_b_i     ),
        .hs_i          ( hs_i          ), .vs_i          ( vs_i          ),
        .board_hsync_i ( board_hsync_i ), .board_vsync_i ( board_vsync_i ),
        .ypbpr_i       ( ypbpr         ),
        .scandoubler_disable_i ( scandoubler_disable ),
        .VGA_R_o       ( VGA_R_o       ), .VGA_G_o       ( VGA_G_o       ),
        .VGA_B_o       ( VGA_B_o       ), .VGA_HS_o      ( VGA_HS_o      ),
        .VGA_VS_o      ( VGA_VS_o      )
    );

endmodule

/* logic/rom_download.sv */
// ------------------------------------------------
// ROM download
// Turns download bytes into ioctl write strobes
// with a per-session address counter
// ------------------------------------------------
`timescale 1ns/1ps

module rom_download
    import base_pkg::*;
(
    input  logic        clk_sys_i,
    input  logic        rst_n_i,
    input  logic        byte_valid_i,
    input  logic        first_byte_i,
    input  logic        ss_active_i,
    input  byte_t       byte_data_i,
    output ioctl_addr_t ioctl_addr_o,
    output byte_t       ioctl_data_o,
    output logic        ioctl_wr_o,
    output logic        downloading_o
);

    ioctl_addr_t next_addr;   // Address of following byte

    always_ff @(posedge clk_sys_i) begin
        if (!rst_n_i) begin
            ioctl_wr_o    <= 1'b0;
            downloading_o <= 1'b0;
            next_addr     <= '0;
            ioctl_addr_o  <= '0;
        end else begin
            ioctl_wr_o <= byte_valid_i;
            if (!ss_active_i)
                downloading_o <= 1'b0;   // Session over
            else if (byte_valid_i)
                downloading_o <= 1'b1;
            if (byte_valid_i) begin
                if (first_byte_i) begin
                    ioctl_addr_o <= '0;   // New session restarts at 0
                    next_addr    <= ioctl_addr_t'(1);
                end else begin
                    ioctl_addr_o <= next_addr;
                    next_addr    <= next_addr + ioctl_addr_t'(1);
                end
            end
        end
    end

    always_ff @(posedge clk_sys_i) begin
        if (byte_valid_i)
            ioctl_data_o <= byte_data_i;
    end

    a_wr_while_dl: assert property (
        @(posedge clk_sys_i) disable iff (!rst_n_i)
        ioctl_wr_o |-> downloading_o
    );

endmodule

/* logic/spi_byte_rx.sv */
// ------------------------------------------------
// SPI byte receiver
// Oversamples SCK, select and data in the system
// clock, assembles MSB-first bytes and flags the
// first byte after each select
// ------------------------------------------------
`timescale 1ns/1ps
`include "base_config.svh"

module spi_byte_rx
    import base_pkg::*;
(
    input  logic  clk_sys_i,
    input  logic  rst_n_i,
    input  logic  sck_i,
    input  logic  ss_n_i,
    input  logic  sdi_i,
    output logic  byte_valid_o,
    output logic  first_byte_o,
    output logic  ss_active_o,
    output byte_t byte_data_o
);

    localparam int MSB = `BASE_SYNC_STAGES - 1;

    logic [MSB:0] sck_sync;
    logic [MSB:0] ss_sync;
    logic [MSB:0] sdi_sync;
    logic         sck_prev;
    logic [2:0]   bit_cnt;
    logic         first_pend;   // Next byte is first of select
    logic [6:0]   shift_q;

    wire sck_rise = sck_sync[MSB] & ~sck_prev;
    wire ss_live  = ~ss_sync[MSB];
    wire sdi_s    = sdi_sync[MSB];

    always_ff @(posedge clk_sys_i) begin
        if (!rst_n_i) begin
            sck_sync     <= '0;
            ss_sync      <= '1;     // Select idle
            sdi_sync     <= '0;
            sck_prev     <= 1'b0;
            ss_active_o  <= 1'b0;
            byte_valid_o <= 1'b0;
            bit_cnt      <= 3'd0;
            first_pend   <= 1'b1;
        end else begin
            sck_sync     <= {sck_sync[MSB-1:0], sck_i};
            ss_sync      <= {ss_sync[MSB-1:0], ss_n_i};
            sdi_sync     <= {sdi_sync[MSB-1:0], sdi_i};
            sck_prev     <= sck_sync[MSB];
            ss_active_o  <= ss_live;   // Aligned with byte_valid_o
            byte_valid_o <= 1'b0;
            if (!ss_live) begin
                bit_cnt    <= 3'd0;     // Partial byte dropped
                first_pend <= 1'b1;
            end else if (sck_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    byte_valid_o <= 1'b1;
                    first_pend   <= 1'b0;
                end
            end
        end
    end

    // Data path
    always_ff @(posedge clk_sys_i) begin
        if (ss_live && sck_rise) begin
            shift_q <= {shift_q[5:0], sdi_s};
            if (bit_cnt == 3'd7) begin
                byte_data_o  <= {shift_q, sdi_s};
                first_byte_o <= first_pend;
            end
        end
    end

    a_valid_in_select: assert property (
        @(posedge clk_sys_i) disable iff (!rst_n_i)
        byte_valid_o |-> ss_active_o
    );

endmodule

/* logic/user_cfg.sv */
// ------------------------------------------------
// User configuration decoder
// Loads joystick, status and video-mode registers
// from command bytes sent on CONF_DATA0
// ------------------------------------------------
`timescale 1ns/1ps
`include "base_config.svh"

module user_cfg
    import base_pkg::*;
(
    input  logic    clk_sys_i,
    input  logic    rst_n_i,
    input  logic    byte_valid_i,
    input  logic    first_byte_i,
    input  logic    ss_active_i,
    input  byte_t   byte_data_i,
    output word32_t joystick1_o,
    output word32_t joystick2_o,
    output word32_t status_o,
    output logic    ypbpr_o,
    output logic    scandoubler_disable_o
);

    cfg_state_t  state_q;
    byte_t       cmd_q;
    logic [1:0]  cnt_q;     // Data bytes taken so far
    logic [23:0] hold_q;    // Upper three bytes of word
    logic        cmd_known;

    wire word32_t word = {hold_q, byte_data_i};

    always_comb begin
        case (byte_data_i)
            `BASE_CMD_JOY0, `BASE_CMD_JOY1,
            `BASE_CMD_STATUS, `BASE_CMD_VMODE: cmd_known = 1'b1;
            default:                           cmd_known = 1'b0;
        endcase
    end

    always_ff @(posedge clk_sys_i) begin
        if (!rst_n_i) begin
            state_q               <= CFG_CMD;
            cnt_q                 <= 2'd0;
            joystick1_o           <= '0;
            joystick2_o           <= '0;
            status_o              <= '0;
            ypbpr_o               <= 1'b0;
            scandoubler_disable_o <= 1'b0;
        end else if (!ss_active_i) begin
            state_q <= CFG_CMD;
            cnt_q   <= 2'd0;
        end else if (byte_valid_i) begin
            case (state_q)
                CFG_CMD: begin
                    cnt_q   <= 2'd0;
                    state_q <= (first_byte_i && cmd_known) ? CFG_DATA : CFG_SKIP;
                end
                CFG_DATA: begin
                    cnt_q <= cnt_q + 2'd1;
                    if (cmd_q == `BASE_CMD_VMODE) begin
                        ypbpr_o               <= byte_data_i[0];
                        scandoubler_disable_o <= byte_data_i[1];
                        state_q               <= CFG_SKIP;
                    end else if (cnt_q == 2'd3) begin
                        // Joystick ports are swapped on this board
                        case (cmd_q)
                            `BASE_CMD_JOY0: joystick2_o <= word;
                            `BASE_CMD_JOY1: joystick1_o <= word;
                            default:        status_o    <= word;
                        endcase
                        state_q <= CFG_SKIP;
                    end
                end
                CFG_SKIP: state_q <= CFG_SKIP;   // Wait for select to end
                default:  state_q <= CFG_SKIP;
            endcase
        end
    end

    // Command and MSB-first word assembly
    always_ff @(posedge clk_sys_i) begin
        if (byte_valid_i) begin
            if (state_q == CFG_CMD)
                cmd_q <= byte_data_i;
            hold_q <= {hold_q[15:0], byte_data_i};
        end
    end

    a_idle_on_deselect: assert property (
        @(posedge clk_sys_i) disable iff (!rst_n_i)
        !ss_active_i |=> state_q == CFG_CMD
    );

endmodule

/* logic/video_out.sv */
// ------------------------------------------------
// Video output stage
// Picks game or scan-doubled colour, builds the
// composite sync and converts to YPbPr on demand,
// all in one register stage
// ------------------------------------------------
`timescale 1ns/1ps

module video_out
    import base_pkg::*;
(
    input  logic    clk_sys_i,
    input  logic    rst_n_i,
    input  color4_t game_r_i,
    input  color4_t game_g_i,
    input  color4_t game_b_i,
    input  color6_t board_r_i,
    input  color6_t board_g_i,
    input  color6_t board_b_i,
    input  logic    hs_i,
    input  logic    vs_i,
    input  logic    board_hsync_i,
    input  logic    board_vsync_i,
    input  logic    ypbpr_i,
    input  logic    scandoubler_disable_i,
    output color6_t VGA_R_o,
    output color6_t VGA_G_o,
    output color6_t VGA_B_o,
    output logic    VGA_HS_o,
    output logic    VGA_VS_o
);

    color6_t            red, green, blue;
    color6_t            luma;
    logic [7:0]         luma_sum;
    logic signed [6:0]  b_diff, r_diff;
    logic signed [6:0]  pb_full, pr_full;
    logic               hsync, vsync, csync;

    always_comb begin
        // Bypass repeats the top bits to fill 6 bits
        red   = scandoubler_disable_i ? {game_r_i, game_r_i[3:2]} : board_r_i;
        green = scandoubler_disable_i ? {game_g_i, game_g_i[3:2]} : board_g_i;
        blue  = scandoubler_disable_i ? {game_b_i, game_b_i[3:2]} : board_b_i;
        hsync = scandoubler_disable_i ? ~hs_i : board_hsync_i;
        vsync = scandoubler_disable_i ? ~vs_i : board_vsync_i;
        csync = ~(hsync ^ vsync);

        luma_sum = {2'b00, red} + {1'b0, green, 1'b0} + {2'b00, blue};
        luma     = luma_sum[7:2];
        b_diff   = $signed({1'b0, blue}) - $signed({1'b0, luma});
        r_diff   = $signed({1'b0, red})  - $signed({1'b0, luma});
        pb_full  = 7'sd32 + (b_diff >>> 1);   // Stays within 0..63
        pr_full  = 7'sd32 + (r_diff >>> 1);
    end

    always_ff @(posedge clk_sys_i) begin
        if (!rst_n_i) begin
            VGA_R_o  <= '0;
            VGA_G_o  <= '0;
            VGA_B_o  <= '0;
            VGA_HS_o <= 1'b0;
            VGA_VS_o <= 1'b0;
        end else begin
            VGA_R_o <= ypbpr_i ? pr_full[5:0] : red;
            VGA_G_o <= ypbpr_i ? luma         : green;
            VGA_B_o <= ypbpr_i ? pb_full[5:0] : blue;
            // SCART cables want composite sync on HS and VCC on VS
            VGA_HS_o <= (scandoubler_disable_i | ypbpr_i) ? csync : hsync;
            VGA_VS_o <= (scandoubler_disable_i | ypbpr_i) ? 1'b1  : vsync;
        end
    end

endmodule

/* tests/tb_mist_base.sv */
// --------------------------------------------------
// MiST board base testbench
// Sends ROM downloads and configuration words over
// SPI, drives random video and checks every output
// port against a model of the board rules
// --------------------------------------------------
`timescale 1ns/1ps
`include "base_config.svh"

module tb_mist_base
    import base_pkg::*;
();

    localparam int MAX_CYCLES = 20000;   // Well above the ~12k cycles of stimulus

    logic        clk_sys_i;
    logic        rst_n_i;
    logic        SPI_SCK_i, SPI_DI_i, SPI_SS2_i, CONF_DATA0_i;
    color4_t     game_r_i, game_g_i, game_b_i;
    color6_t     board_r_i, board_g_i, board_b_i;
    logic        hs_i, vs_i, board_hsync_i, board_vsync_i;
    ioctl_addr_t ioctl_addr_o;
    byte_t       ioctl_data_o;
    logic        ioctl_wr_o, downloading_o;
    word32_t     joystick1_o, joystick2_o, status_o;
    color6_t     VGA_R_o, VGA_G_o, VGA_B_o;
    logic        VGA_HS_o, VGA_VS_o;

    int          seed = 32'h6ccf;       // SPI bytes and words
    int          vid_seed = 32'h6ccf;   // Video inputs
    string       test_name = "reset";
    int          err_main = 0, err_chk = 0, err_pulse = 0, err_rst = 0;
    int          cycles = 0;
    logic        video_chk = 1'b0;
    logic        mode_ypbpr = 1'b0, mode_bypass = 1'b0;
    logic        exp_valid = 1'b0;
    logic [19:0] exp_vid;               // {R, G, B, HS, VS}
    logic        dl_open = 1'b0;        // Download session in progress
    int          dl_len = 0;
    int          dl_idx = 0;            // Writes seen in this session
    byte_t       dl_bytes [0:15];
    logic [29:0] dl_exp;
    word32_t     exp_joy1 = '0, exp_joy2 = '0, exp_status = '0;

    wire [19:0] vga_now = {VGA_R_o, VGA_G_o, VGA_B_o, VGA_HS_o, VGA_VS_o};
    wire [95:0] cfg_now = {joystick1_o, joystick2_o, status_o};

    mist_base dut (.*);

    initial begin
        clk_sys_i = 1'b0;
        forever #20 clk_sys_i = ~clk_sys_i;
    end

    // Fresh random video every cycle
    initial begin : drive_video
        logic [31:0] rnd;
        {game_r_i, game_g_i, game_b_i}    = 12'd0;
        {board_r_i, board_g_i, board_b_i} = 18'd0;
        {hs_i, vs_i, board_hsync_i, board_vsync_i} = 4'd0;
        forever begin
            @(posedge clk_sys_i);
            #2;
            rnd = $random(vid_seed);
            {game_r_i, game_g_i, game_b_i}    = rnd[11:0];
            {board_r_i, board_g_i, board_b_i} = rnd[29:12];
            {hs_i, vs_i} = rnd[31:30];
            rnd = $random(vid_seed);
            {board_hsync_i, board_vsync_i} = rnd[1:0];
        end
    end

    // Expected VGA word from the output rules
    function automatic logic [19:0] video_model(
        input color4_t gr, input color4_t gg, input color4_t gb,
        input color6_t br, input color6_t bg, input color6_t bb,
        input logic hs, input logic vs, input logic bhs, input logic bvs,
        input logic ypbpr, input logic bypass
    );
        int   r, g, b, y, pb, pr;
        logic hsync, vsync, csync, comp;
        if (bypass) begin
            r     = {26'd0, gr, gr[3:2]};   // Top bits repeated below
            g     = {26'd0, gg, gg[3:2]};
            b     = {26'd0, gb, gb[3:2]};
            hsync = ~hs;
            vsync = ~vs;
        end else begin
            r     = {26'd0, br};
            g     = {26'd0, bg};
            b     = {26'd0, bb};
            hsync = bhs;
            vsync = bvs;
        end
        csync = ~(hsync ^ vsync);
        comp  = bypass | ypbpr;   // SCART style sync
        if (ypbpr) begin
            y  = (r + 2 * g + b) >>> 2;
            pb = 32 + ((b - y) >>> 1);
            pr = 32 + ((r - y) >>> 1);
            r  = pr;
            g  = y;
            b  = pb;
        end
        return {r[5:0], g[5:0], b[5:0], comp ? csync : hsync, comp ? 1'b1 : vsync};
    endfunction

    // Video and ROM write scoreboard
    always @(posedge clk_sys_i) begin
        if (exp_valid)
            assert (vga_now == exp_vid) else begin
                err_chk++;
                $display("mismatch %s video expected %h actual %h",
                         test_name, exp_vid, vga_now);
            end
        exp_vid <= video_model(game_r_i, game_g_i, game_b_i, board_r_i, board_g_i,
                               board_b_i, hs_i, vs_i, board_hsync_i, board_vsync_i,
                               mode_ypbpr, mode_bypass);
        exp_valid <= video_chk & rst_n_i;
        if (rst_n_i && ioctl_wr_o) begin
            if (!dl_open || dl_idx >= dl_len) begin
                err_chk++;
                $display("%s: write strobe outside a download session", test_name);
            end else begin
                dl_exp = {ioctl_addr_t'(dl_idx), dl_bytes[dl_idx[3:0]]};
                assert ({ioctl_addr_o, ioctl_data_o} == dl_exp) else begin
                    err_chk++;
                    $display("mismatch %s write addr/data expected %h actual %h",
                             test_name, dl_exp, {ioctl_addr_o, ioctl_data_o});
                end
            end
            dl_idx++;
        end else if (!dl_open) begin
            dl_idx = 0;
        end
    end

    a_wr_pulse: assert property (@(posedge clk_sys_i) disable iff (!rst_n_i)
        ioctl_wr_o |=> !ioctl_wr_o)
        else begin
            err_pulse++;
            $display("%s: ioctl_wr_o stayed high for two cycles", test_name);
        end

    a_reset_low: assert property (@(posedge clk_sys_i)
        !rst_n_i |=> !ioctl_wr_o && !downloading_o && cfg_now == '0 && vga_now == '0)
        else begin
            err_rst++;
            $display("%s: outputs not cleared while reset was held", test_name);
        end

    always @(posedge clk_sys_i) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic tick(input int n);
        repeat (n) @(posedge clk_sys_i);
        #2;
    endtask

    // MSB first, DI settles while SCK is low
    task automatic send_byte(input byte_t b);
        for (int i = 7; i >= 0; i--) begin
            SPI_SCK_i = 1'b0;
            SPI_DI_i  = b[i];
            tick(4);
            SPI_SCK_i = 1'b1;
            tick(4);
        end
    endtask

    task automatic open_select(input logic dl);
        SPI_SS2_i    = ~dl;
        CONF_DATA0_i = dl;
        tick(4);
    endtask

    task automatic close_select();
        SPI_SCK_i = 1'b0;
        tick(4);
        SPI_SS2_i    = 1'b1;
        CONF_DATA0_i = 1'b1;
        tick(8);
    endtask

    task automatic send_cfg(input byte_t cmd, input word32_t w, input int n);
        open_select(1'b0);
        send_byte(cmd);
        for (int i = n - 1; i >= 0; i--)
            send_byte(w[8*i +: 8]);
        close_select();
    endtask

    task automatic check_cfg();
        assert (joystick1_o == exp_joy1) else begin
            err_main++;
            $display("mismatch %s joystick1_o expected %h actual %h",
                     test_name, exp_joy1, joystick1_o);
        end
        assert (joystick2_o == exp_joy2) else begin
            err_main++;
            $display("mismatch %s joystick2_o expected %h actual %h",
                     test_name, exp_joy2, joystick2_o);
        end
        assert (status_o == exp_status) else begin
            err_main++;
            $display("mismatch %s status_o expected %h actual %h",
                     test_name, exp_status, status_o);
        end
    endtask

    // Mode bits change mid-session, so video checks pause meanwhile
    task automatic set_vmode(input logic ypbpr, input logic bypass);
        video_chk = 1'b0;
        send_cfg(`BASE_CMD_VMODE, {30'd0, bypass, ypbpr}, 1);
        mode_ypbpr  = ypbpr;
        mode_bypass = bypass;
        video_chk   = 1'b1;
    endtask

    task automatic run_download(input int n);
        logic [31:0] rnd;
        int          wait_cnt;
        dl_len  = n;
        open_select(1'b1);   // Write count clears while no session is open
        dl_open = 1'b1;
        for (int i = 0; i < n; i++) begin
            rnd = $random(seed);
            dl_bytes[i] = rnd[7:0];
            send_byte(rnd[7:0]);
        end
        assert (downloading_o) else begin
            err_main++;
            $display("%s: downloading_o low during the session", test_name);
        end
        close_select();
        wait_cnt = 0;
        while (downloading_o && wait_cnt < 16) begin
            tick(1);
            wait_cnt++;
        end
        assert (!downloading_o) else begin
            err_main++;
            $display("%s: downloading_o still high after the select dropped", test_name);
        end
        assert (dl_idx == n) else begin
            err_main++;
            $display("mismatch %s write count expected %0d actual %0d", test_name, n, dl_idx);
        end
        dl_open = 1'b0;
    endtask

    initial begin : main
        word32_t w;
        int      total;
        rst_n_i      = 1'b0;
        SPI_SCK_i    = 1'b0;
        SPI_DI_i     = 1'b0;
        SPI_SS2_i    = 1'b1;
        CONF_DATA0_i = 1'b1;
        tick(8);
        rst_n_i   = 1'b1;
        video_chk = 1'b1;   // Scan mode RGB after reset
        check_cfg();

        test_name = "download";
        run_download(16);
        run_download(16);   // Address restarts at 0

        test_name = "config";
        w = $random(seed);
        exp_joy2 = w;
        send_cfg(`BASE_CMD_JOY0, w, 4);
        check_cfg();
        w = $random(seed);
        exp_joy1 = w;
        send_cfg(`BASE_CMD_JOY1, w, 4);
        check_cfg();
        w = $random(seed);
        exp_status = w;
        send_cfg(`BASE_CMD_STATUS, w, 4);
        check_cfg();
        w = $random(seed);
        send_cfg(8'h55, w, 4);   // Unknown command
        check_cfg();

        test_name = "bypass";
        set_vmode(1'b0, 1'b1);
        tick(2500);
        test_name = "ypbpr";
        set_vmode(1'b1, 1'b0);
        tick(2500);
        test_name = "scan";
        set_vmode(1'b0, 1'b0);
        tick(2500);

        total = err_main + err_chk + err_pulse + err_rst;
        $display("errors: %0d (procedural %0d, scoreboard %0d, pulse %0d, reset %0d)",
                 total, err_main, err_chk, err_pulse, err_rst);
        if (total == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+logic
logic/base_pkg.sv
logic/spi_byte_rx.sv
logic/rom_download.sv
logic/user_cfg.sv
logic/video_out.sv
logic/mist_base.sv
tests/tb_mist_base.sv
